//--- Bender.yml
package:
  name: mips_core

sources:
  # synthesizable core, package first
  - files:
      - hdl/mipsPkg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/hazardUnit.sv
      - hdl/executeStage.sv
      - hdl/memWbStage.sv
      - hdl/mipsCore.sv

  # bound checker and testbench top tb_mipsCore
  - target: test
    files:
      - testbench/mipsCore_chk.sv
      - testbench/tb_mipsCore.sv

//--- hdl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage (
	input  wire                    clk,
	input  wire                    rstN,
	input  wire                    stallD,
	input  wire mipsPkg::word_t    instrF,
	input  wire mipsPkg::word_t    pcF,
	input  wire mipsPkg::word_t    pcPlus4F,
	input  wire mipsPkg::word_t    aluOutM,
	input  wire mipsPkg::word_t    resultW,
	input  wire mipsPkg::regAddr_t writeRegW,
	input  wire                    regWriteW,
	input  wire                    forwardAD,
	input  wire                    forwardBD,
	output mipsPkg::idEx_t         decodedD,
	output mipsPkg::regAddr_t      rsD,
	output mipsPkg::regAddr_t      rtD,
	output logic                   isBranchD,
	output logic                   branchTaken,
	output logic                   jump,
	output mipsPkg::word_t         branchTarget,
	output mipsPkg::word_t         jumpTarget
);
	import mipsPkg::*;

	word_t      instrD;
	word_t      pcD;
	word_t      pcPlus4D;
	logic [5:0] opD;
	logic [5:0] functD;
	regAddr_t   rdD;
	regAddr_t   destD;
	word_t      signImmD;
	word_t      rfA;
	word_t      rfB;
	word_t      cmpA;
	word_t      cmpB;
	ctrl_t      ctrlD;
	word_t      regFile [32];

	////////////////////////////////////////
	// if/id register
	////////////////////////////////////////

	// instr reset to zero decodes as sll $0 i.e. a nop
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD      <= pcF;
			pcPlus4D <= pcPlus4F;
		end
	end

	// instruction fields
	assign opD    = instrD[31:26];
	assign functD = instrD[5:0];
	assign rsD    = instrD[25:21];
	assign rtD    = instrD[20:16];
	assign rdD    = instrD[15:11];

	////////////////////////////////////////
	// control decode
	////////////////////////////////////////

	always_comb begin
		ctrlD     = '0;
		isBranchD = 1'b0;
		jump      = 1'b0;
		case (opD)
			opRtype: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.regDst   = 1'b1;
				case (functD)
					fnAddu:  ctrlD.aluOp = aluAdd;
					fnSubu:  ctrlD.aluOp = aluSub;
					fnAnd:   ctrlD.aluOp = aluAnd;
					fnOr:    ctrlD.aluOp = aluOr;
					fnSlt:   ctrlD.aluOp = aluSlt;
					fnSll:   ctrlD.aluOp = aluSll;
					// unsupported funct retires as nothing
					default: ctrlD.regWrite = 1'b0;
				endcase
			end
			opAddiu: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.aluSrc   = 1'b1;
			end
			opLw: begin
				ctrlD.regWrite = 1'b1;
				ctrlD.memToReg = 1'b1;
				ctrlD.aluSrc   = 1'b1;
			end
			opSw: begin
				ctrlD.memWrite = 1'b1;
				ctrlD.aluSrc   = 1'b1;
			end
			opBeq:   isBranchD = 1'b1;
			opJ:     jump = 1'b1;
			default: ctrlD = '0;
		endcase
		// drop writes to $0 here, so forwarding never compares against zero
		destD = ctrlD.regDst ? rdD : rtD;
		if (destD == '0) begin
			ctrlD.regWrite = 1'b0;
		end
	end

	////////////////////////////////////////
	// register file
	////////////////////////////////////////

	// written on the falling edge: wb value visible to decode same cycle
	always_ff @(negedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < 32; i++) begin
				regFile[i] <= '0;
			end
		end else if (regWriteW) begin
			regFile[writeRegW] <= resultW;
		end
	end

	// $0 is never written, stays zero from reset
	assign rfA = regFile[rsD];
	assign rfB = regFile[rtD];

	// beq compare with mem-stage forwarding
	assign cmpA        = forwardAD ? aluOutM : rfA;
	assign cmpB        = forwardBD ? aluOutM : rfB;
	assign branchTaken = isBranchD && (cmpA == cmpB);

	// immediate and targets, both relative to the slot
	assign signImmD     = {{16{instrD[15]}}, instrD[15:0]};
	assign branchTarget = pcPlus4D + {signImmD[29:0], 2'b00};
	assign jumpTarget   = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	// raw rf values, execute forwards from m and w
	assign decodedD = '{
		ctrl:    ctrlD,
		pc:      pcD,
		srcA:    rfA,
		srcB:    rfB,
		signImm: signImmD,
		rs:      rsD,
		rt:      rtD,
		rd:      rdD,
		sa:      instrD[10:6]
	};

endmodule

`default_nettype wire

//--- hdl/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire                 flushE,
	input  wire mipsPkg::idEx_t decodedD,
	input  wire [1:0]           forwardAE,
	input  wire [1:0]           forwardBE,
	input  wire mipsPkg::word_t aluOutM,
	input  wire mipsPkg::word_t resultW,
	output mipsPkg::idEx_t      decodedE,
	output mipsPkg::regAddr_t   writeRegE,
	output mipsPkg::exMem_t     executedE
);
	import mipsPkg::*;

	word_t srcAFwd;
	word_t srcBFwd;
	word_t aluB;
	word_t aluOut;

	////////////////////////////////////////
	// id/ex register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			decodedE <= '0;
		end else if (flushE) begin
			// bubble, all control zero
			decodedE <= '0;
		end else begin
			decodedE <= decodedD;
		end
	end

	// operand select, same encoding as hazard unit
	assign srcAFwd = (forwardAE == 2'b10) ? aluOutM :
		(forwardAE == 2'b01) ? resultW : decodedE.srcA;
	assign srcBFwd = (forwardBE == 2'b10) ? aluOutM :
		(forwardBE == 2'b01) ? resultW : decodedE.srcB;

	// immediate for addiu/lw/sw
	assign aluB = decodedE.ctrl.aluSrc ? decodedE.signImm : srcBFwd;

	// six-op alu
	always_comb begin
		case (decodedE.ctrl.aluOp)
			aluAdd:  aluOut = srcAFwd + aluB;
			aluSub:  aluOut = srcAFwd - aluB;
			aluAnd:  aluOut = srcAFwd & aluB;
			aluOr:   aluOut = srcAFwd | aluB;
			aluSlt:  aluOut = {31'd0, $signed(srcAFwd) < $signed(aluB)};
			// sll shifts rt by the sa field
			aluSll:  aluOut = aluB << decodedE.sa;
			default: aluOut = '0;
		endcase
	end

	// rd for r-type, rt otherwise
	assign writeRegE = decodedE.ctrl.regDst ? decodedE.rd : decodedE.rt;

	// store data is the forwarded rt, not the immediate
	assign executedE = '{
		ctrl:      decodedE.ctrl,
		pc:        decodedE.pc,
		aluOut:    aluOut,
		writeData: srcBFwd,
		writeReg:  writeRegE
	};

endmodule

`default_nettype wire

//--- hdl/fetchStage.sv
`timescale 1ns/10ps
`default_nettype none

module fetchStage #(
	parameter mipsPkg::word_t resetPc = 32'h0000_0000
) (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire                 stallF,
	input  wire                 branchTaken,
	input  wire                 jump,
	input  wire mipsPkg::word_t branchTarget,
	input  wire mipsPkg::word_t jumpTarget,
	output mipsPkg::word_t      pcF,
	output mipsPkg::word_t      pcPlus4F
);
	import mipsPkg::*;

	word_t pcNext;

	// sequential fetch address
	assign pcPlus4F = pcF + 32'd4;

	// jump first, then taken branch, else fall through
	// both redirects come from decode, so the slot at pcF still goes down
	always_comb begin
		if (jump) begin
			pcNext = jumpTarget;
		end else if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pcPlus4F;
		end
	end

	// pc register, frozen on a stall
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

endmodule

`default_nettype wire

//--- hdl/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
	input  wire mipsPkg::regAddr_t rsD,
	input  wire mipsPkg::regAddr_t rtD,
	input  wire                    isBranchD,
	input  wire mipsPkg::idEx_t    decodedE,
	input  wire mipsPkg::regAddr_t writeRegE,
	input  wire mipsPkg::exMem_t   exM,
	input  wire mipsPkg::regAddr_t writeRegW,
	input  wire                    regWriteW,
	output logic                   stallF,
	output logic                   stallD,
	output logic                   flushE,
	output logic                   forwardAD,
	output logic                   forwardBD,
	output logic [1:0]             forwardAE,
	output logic [1:0]             forwardBE
);
	import mipsPkg::*;

	regAddr_t rsE;
	regAddr_t rtE;
	logic     eWritesD;
	logic     mLoadsD;
	logic     loadUseStall;
	logic     branchStall;

	assign rsE = decodedE.rs;
	assign rtE = decodedE.rt;

	// decode compare only sees mem stage alu result
	assign forwardAD = exM.ctrl.regWrite && (exM.writeReg == rsD);
	assign forwardBD = exM.ctrl.regWrite && (exM.writeReg == rtD);

	// 10 mem alu result, 01 wb result, 00 register file
	// mem checked first since it is newer
	assign forwardAE = (exM.ctrl.regWrite && (exM.writeReg == rsE)) ? 2'b10 :
		(regWriteW && (writeRegW == rsE)) ? 2'b01 : 2'b00;
	assign forwardBE = (exM.ctrl.regWrite && (exM.writeReg == rtE)) ? 2'b10 :
		(regWriteW && (writeRegW == rtE)) ? 2'b01 : 2'b00;

	////////////////////////////////////////
	// stalls
	////////////////////////////////////////

	// e result targets a decode source
	assign eWritesD = decodedE.ctrl.regWrite && ((writeRegE == rsD) || (writeRegE == rtD));

	// load in mem targets a decode source, data not back until wb
	assign mLoadsD = exM.ctrl.memToReg && exM.ctrl.regWrite &&
		((exM.writeReg == rsD) || (exM.writeReg == rtD));

	// load in e feeding anything in d
	assign loadUseStall = decodedE.ctrl.memToReg && eWritesD;

	// beq compares in d, so any pending producer ahead holds it
	assign branchStall = isBranchD && (eWritesD || mLoadsD);

	// hold f and d, put a bubble into e
	assign stallF = loadUseStall || branchStall;
	assign stallD = loadUseStall || branchStall;
	assign flushE = loadUseStall || branchStall;

endmodule

`default_nettype wire

//--- hdl/memWbStage.sv
`timescale 1ns/10ps
`default_nettype none

module memWbStage (
	input  wire                  clk,
	input  wire                  rstN,
	input  wire mipsPkg::exMem_t executedE,
	input  wire mipsPkg::word_t  readDataM,
	output mipsPkg::exMem_t      exM,
	output logic                 memWriteM,
	output mipsPkg::word_t       aluOutM,
	output mipsPkg::word_t       writeDataM,
	output mipsPkg::word_t       resultW,
	output mipsPkg::regAddr_t    writeRegW,
	output logic                 regWriteW,
	output mipsPkg::word_t       debugWbPc,
	output logic                 debugWbRfWen,
	output mipsPkg::regAddr_t    debugWbRfWnum,
	output mipsPkg::word_t       debugWbRfWdata
);
	import mipsPkg::*;

	memWb_t memWb;

	////////////////////////////////////////
	// ex/mem register and data port
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			exM <= '0;
		end else begin
			exM <= executedE;
		end
	end

	// word access only, memory answers in the same cycle
	assign memWriteM  = exM.ctrl.memWrite;
	assign aluOutM    = exM.aluOut;
	assign writeDataM = exM.writeData;

	////////////////////////////////////////
	// mem/wb register
	////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			memWb <= '0;
		end else begin
			memWb <= '{
				regWrite: exM.ctrl.regWrite,
				memToReg: exM.ctrl.memToReg,
				pc:       exM.pc,
				aluOut:   exM.aluOut,
				readData: readDataM,
				writeReg: exM.writeReg
			};
		end
	end

	// load data or alu result back to the rf
	assign resultW   = memWb.memToReg ? memWb.readData : memWb.aluOut;
	assign writeRegW = memWb.writeReg;
	assign regWriteW = memWb.regWrite;

	// retirement trace, one entry per rf write
	assign debugWbPc      = memWb.pc;
	assign debugWbRfWen   = memWb.regWrite;
	assign debugWbRfWnum  = memWb.writeReg;
	assign debugWbRfWdata = resultW;

endmodule

`default_nettype wire

//--- hdl/mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore #(
	parameter mipsPkg::word_t resetPc = 32'h0000_0000
) (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire mipsPkg::word_t instrF,
	input  wire mipsPkg::word_t readDataM,
	output mipsPkg::word_t      pcF,
	output logic                memWriteM,
	output mipsPkg::word_t      aluOutM,
	output mipsPkg::word_t      writeDataM,
	output mipsPkg::word_t      debugWbPc,
	output logic                debugWbRfWen,
	output mipsPkg::regAddr_t   debugWbRfWnum,
	output mipsPkg::word_t      debugWbRfWdata
);
	import mipsPkg::*;

	// fetch/decode
	word_t    pcPlus4F;
	logic     branchTaken;
	logic     jump;
	word_t    branchTarget;
	word_t    jumpTarget;
	idEx_t    decodedD;
	regAddr_t rsD;
	regAddr_t rtD;
	logic     isBranchD;
	// hazard
	logic       stallF;
	logic       stallD;
	logic       flushE;
	logic       forwardAD;
	logic       forwardBD;
	logic [1:0] forwardAE;
	logic [1:0] forwardBE;
	// execute, mem, wb
	idEx_t    decodedE;
	regAddr_t writeRegE;
	exMem_t   executedE;
	exMem_t   exM;
	word_t    resultW;
	regAddr_t writeRegW;
	logic     regWriteW;

	////////////////////////////////////////
	// input side
	////////////////////////////////////////

	fetchStage #(
		.resetPc(resetPc)
	) u_fetch (
		.clk(clk),
		.rstN(rstN),
		.stallF(stallF),
		.branchTaken(branchTaken),
		.jump(jump),
		.branchTarget(branchTarget),
		.jumpTarget(jumpTarget),
		.pcF(pcF),
		.pcPlus4F(pcPlus4F)
	);

	////////////////////////////////////////
	// decode, hazard, execute
	////////////////////////////////////////

	decodeStage u_decode (
		.clk(clk),
		.rstN(rstN),
		.stallD(stallD),
		.instrF(instrF),
		.pcF(pcF),
		.pcPlus4F(pcPlus4F),
		.aluOutM(aluOutM),
		.resultW(resultW),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.decodedD(decodedD),
		.rsD(rsD),
		.rtD(rtD),
		.isBranchD(isBranchD),
		.branchTaken(branchTaken),
		.jump(jump),
		.branchTarget(branchTarget),
		.jumpTarget(jumpTarget)
	);

	hazardUnit u_hazard (
		.rsD(rsD),
		.rtD(rtD),
		.isBranchD(isBranchD),
		.decodedE(decodedE),
		.writeRegE(writeRegE),
		.exM(exM),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.stallF(stallF),
		.stallD(stallD),
		.flushE(flushE),
		.forwardAD(forwardAD),
		.forwardBD(forwardBD),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE)
	);

	executeStage u_execute (
		.clk(clk),
		.rstN(rstN),
		.flushE(flushE),
		.decodedD(decodedD),
		.forwardAE(forwardAE),
		.forwardBE(forwardBE),
		.aluOutM(aluOutM),
		.resultW(resultW),
		.decodedE(decodedE),
		.writeRegE(writeRegE),
		.executedE(executedE)
	);

	////////////////////////////////////////
	// output side, memory and trace
	////////////////////////////////////////

	memWbStage u_memWb (
		.clk(clk),
		.rstN(rstN),
		.executedE(executedE),
		.readDataM(readDataM),
		.exM(exM),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.resultW(resultW),
		.writeRegW(writeRegW),
		.regWriteW(regWriteW),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

endmodule

`default_nettype wire

//--- hdl/mipsPkg.sv
`default_nettype none

package mipsPkg;

	////////////////////////////////////////
	// widths with a meaning
	////////////////////////////////////////

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [2:0]  aluOp_t;

	// alu operation codes
	localparam aluOp_t aluAdd = 3'd0;
	localparam aluOp_t aluSub = 3'd1;
	localparam aluOp_t aluAnd = 3'd2;
	localparam aluOp_t aluOr  = 3'd3;
	localparam aluOp_t aluSlt = 3'd4;
	localparam aluOp_t aluSll = 3'd5;

	// primary opcodes, instr[31:26]
	localparam logic [5:0] opRtype = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// function field for r-type, instr[5:0]
	localparam logic [5:0] fnSll  = 6'h00;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	////////////////////////////////////////
	// pipeline register contents
	////////////////////////////////////////

	// all zero is a bubble
	typedef struct packed {
		logic   regWrite;
		logic   memToReg;
		logic   memWrite;
		logic   aluSrc;
		logic   regDst;
		aluOp_t aluOp;
	} ctrl_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pc;
		word_t    srcA;
		word_t    srcB;
		word_t    signImm;
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		logic [4:0] sa;
	} idEx_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pc;
		word_t    aluOut;
		word_t    writeData;
		regAddr_t writeReg;
	} exMem_t;

	typedef struct packed {
		logic     regWrite;
		logic     memToReg;
		word_t    pc;
		word_t    aluOut;
		word_t    readData;
		regAddr_t writeReg;
	} memWb_t;

endpackage

`default_nettype wire

//--- testbench/mipsCore_chk.sv
`timescale 1ns/10ps
`default_nettype none

module mipsCore_chk #(
	parameter mipsPkg::word_t resetPc = 32'h0000_0000
) (
	input wire                    clk,
	input wire                    rstN,
	input wire mipsPkg::word_t    pcF,
	input wire                    stallF,
	input wire                    memWriteM,
	input wire                    debugWbRfWen,
	input wire mipsPkg::regAddr_t debugWbRfWnum
);
	import mipsPkg::*;

	// failed assertions so far
	int failCount = 0;

	////////////////////////////////////////
	// reset state
	////////////////////////////////////////

	resetState: assert property (@(posedge clk)
		!rstN |-> (pcF == resetPc) && !memWriteM && !debugWbRfWen)
	else begin
		$error("pc, store strobe or trace enable not in reset state during reset");
		failCount++;
	end

	// bubbles still in flight one cycle after release
	resetExit: assert property (@(posedge clk)
		$rose(rstN) |-> (pcF == resetPc) ##1 (!memWriteM && !debugWbRfWen))
	else begin
		$error("store strobe or trace enable set on the first cycle after reset");
		failCount++;
	end

	////////////////////////////////////////
	// stall and register zero
	////////////////////////////////////////

	// fetch must freeze for a stalled cycle
	stallHold: assert property (@(posedge clk) disable iff (!rstN)
		stallF |=> $stable(pcF))
	else begin
		$error("pc moved while fetch was stalled");
		failCount++;
	end

	// $0 writes dropped in decode
	noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
		debugWbRfWen |-> (debugWbRfWnum != '0))
	else begin
		$error("register zero written back");
		failCount++;
	end

endmodule

bind mipsCore mipsCore_chk #(
	.resetPc(resetPc)
) u_chk (
	.clk(clk),
	.rstN(rstN),
	.pcF(pcF),
	.stallF(stallF),
	.memWriteM(memWriteM),
	.debugWbRfWen(debugWbRfWen),
	.debugWbRfWnum(debugWbRfWnum)
);

`default_nettype wire

//--- testbench/tb_mipsCore.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mipsCore;
	import mipsPkg::*;

	localparam int    clkPeriod = 100;
	localparam int    romSize   = 512;
	localparam int    memWords  = 64;
	localparam int    nGroups   = 10;
	localparam int    randPerGroup = 20;
	localparam word_t resetPc   = 32'h0000_1000;

	// one expected rf write, tagged with its test group
	typedef struct packed {
		logic [7:0] group;
		word_t      pc;
		regAddr_t   num;
		word_t      data;
	} retire_t;

	typedef struct packed {
		word_t addr;
		word_t data;
	} store_t;

	logic     clk;
	logic     rstN;
	word_t    instrF;
	word_t    readDataM;
	word_t    pcF;
	logic     memWriteM;
	word_t    aluOutM;
	word_t    writeDataM;
	word_t    debugWbPc;
	logic     debugWbRfWen;
	regAddr_t debugWbRfWnum;
	word_t    debugWbRfWdata;

	integer  seed;
	word_t   rom [romSize];
	int      romGroup [romSize];
	word_t   dataMem [memWords];
	word_t   romIdx;
	int      progLen;
	int      curGroup;
	logic    progReady = 1'b0;
	retire_t expRet [$];
	store_t  expSt [$];
	int      retIdx;
	int      stIdx;
	int      errCount;
	int      groupExp [nGroups];
	int      groupSeen [nGroups];
	string   patternName [5] = '{"store then load", "load-use", "load then beq",
		"alu then beq", "jump with slot"};

	mipsCore #(
		.resetPc(resetPc)
	) u_dut (
		.clk(clk),
		.rstN(rstN),
		.instrF(instrF),
		.readDataM(readDataM),
		.pcF(pcF),
		.memWriteM(memWriteM),
		.aluOutM(aluOutM),
		.writeDataM(writeDataM),
		.debugWbPc(debugWbPc),
		.debugWbRfWen(debugWbRfWen),
		.debugWbRfWnum(debugWbRfWnum),
		.debugWbRfWdata(debugWbRfWdata)
	);

	////////////////////////////////////////
	// memory models
	////////////////////////////////////////

	// async read, nop outside the program
	assign romIdx    = (pcF - resetPc) >> 2;
	assign instrF    = (romIdx < romSize) ? rom[romIdx] : '0;
	assign readDataM = dataMem[aluOutM[7:2]];

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// initial data memory contents, depends on the byte address
	function automatic word_t fillWord(input word_t addr);
		return 32'hc0de_0000 + (addr * 32'h0001_0001);
	endfunction

	function automatic int pick(input int n);
		return {$random(seed)} % n;
	endfunction

	////////////////////////////////////////
	// instruction encoders
	////////////////////////////////////////

	function automatic word_t encR(input int rs, input int rt, input int rd, input int sa,
		input logic [5:0] fn);
		return {opRtype, rs[4:0], rt[4:0], rd[4:0], sa[4:0], fn};
	endfunction

	function automatic word_t encI(input logic [5:0] op, input int rs, input int rt,
		input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic word_t encJ(input word_t target);
		return {opJ, target[27:2]};
	endfunction

	task automatic emit(input word_t instr);
		rom[progLen]      = instr;
		romGroup[progLen] = curGroup;
		progLen++;
	endtask

	// alu or addiu over r0..r7, dense dependencies
	task automatic emitRandomAlu();
		int rs;
		int rt;
		int rd;
		rs = pick(8);
		rt = pick(8);
		rd = pick(8);
		case (pick(7))
			0: emit(encR(rs, rt, rd, 0, fnAddu));
			1: emit(encR(rs, rt, rd, 0, fnSubu));
			2: emit(encR(rs, rt, rd, 0, fnAnd));
			3: emit(encR(rs, rt, rd, 0, fnOr));
			4: emit(encR(rs, rt, rd, 0, fnSlt));
			5: emit(encR(0, rt, rd, pick(32), fnSll));
			default: emit(encI(opAddiu, rs, rd, $random(seed)));
		endcase
	endtask

	task automatic emitPattern(input int kind);
		int ra;
		int rb;
		int rc;
		int off;
		ra  = 1 + pick(7);
		rb  = 1 + pick(7);
		rc  = (rb % 7) + 1;
		off = 4 * pick(memWords);
		case (kind)
			0: begin
				// store data likely forwarded, then reload it
				emit(encI(opSw, 0, ra, off));
				emit(encI(opLw, 0, rb, off));
				emit(encR(rb, ra, rc, 0, fnAddu));
			end
			1: begin
				emit(encI(opLw, 0, ra, off));
				emit(encR(ra, ra, rb, 0, fnAddu));
				emit(encI(opSw, 0, rb, 4 * pick(memWords)));
			end
			2: begin
				// beq on a fresh load, always taken
				emit(encI(opLw, 0, ra, off));
				emit(encI(opBeq, ra, ra, 2));
				emit(encI(opAddiu, 0, rb, 16'h0111));
				emit(encI(opAddiu, 0, rb, 16'h0222));
				emit(encR(rb, ra, rc, 0, fnOr));
			end
			3: begin
				// taken on a copy, then not taken on rb+1
				emit(encR(rb, 0, ra, 0, fnAddu));
				emit(encI(opBeq, ra, rb, 2));
				emit(encI(opAddiu, rc, rc, 1));
				emit(encI(opAddiu, rc, rc, 100));
				emit(encI(opAddiu, rb, rc, 1));
				emit(encI(opBeq, rc, rb, 2));
				emit(encR(rc, rb, ra, 0, fnSubu));
				emit(encR(rc, rb, ra, 0, fnSlt));
			end
			default: begin
				// j over one word, slot still runs
				emit(encJ(resetPc + 4 * (progLen + 3)));
				emit(encI(opAddiu, ra, ra, 3));
				emit(encI(opAddiu, ra, ra, 1000));
				emit(encR(ra, ra, rb, 0, fnAddu));
			end
		endcase
	endtask

	task automatic buildProgram();
		for (int i = 0; i < romSize; i++) begin
			rom[i]      = '0;
			romGroup[i] = 0;
		end
		progLen = 0;
		for (int g = 0; g < nGroups; g++) begin
			curGroup = g;
			for (int i = 0; i < randPerGroup; i++) begin
				emitRandomAlu();
			end
			emitPattern(g % 5);
		end
		// self-jump with a nop slot ends the program
		emit(encJ(resetPc + 4 * progLen));
		emit('0);
	endtask

	////////////////////////////////////////
	// reference interpreter
	////////////////////////////////////////

	// program order, branch and jump take effect after the slot
	task automatic runReference();
		word_t   regs [32];
		word_t   refMem [memWords];
		word_t   pc;
		word_t   npc;
		word_t   nextNpc;
		word_t   instr;
		word_t   a;
		word_t   b;
		word_t   imm;
		word_t   res;
		word_t   addr;
		word_t   target;
		int      idx;
		int      rs;
		int      rt;
		int      rd;
		int      wrReg;
		int      steps;
		logic    done;
		retire_t ret;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < memWords; i++) begin
			refMem[i] = fillWord(4 * i);
		end
		pc    = resetPc;
		npc   = resetPc + 32'd4;
		done  = 1'b0;
		steps = 0;
		while (!done && steps < 4 * romSize) begin
			idx     = (pc - resetPc) >> 2;
			instr   = (idx >= 0 && idx < romSize) ? rom[idx] : '0;
			rs      = instr[25:21];
			rt      = instr[20:16];
			rd      = instr[15:11];
			a       = regs[rs];
			b       = regs[rt];
			imm     = {{16{instr[15]}}, instr[15:0]};
			nextNpc = npc + 32'd4;
			wrReg   = 0;
			res     = '0;
			case (instr[31:26])
				opRtype: begin
					wrReg = rd;
					case (instr[5:0])
						fnAddu:  res = a + b;
						fnSubu:  res = a - b;
						fnAnd:   res = a & b;
						fnOr:    res = a | b;
						fnSlt:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						fnSll:   res = b << instr[10:6];
						default: wrReg = 0;
					endcase
				end
				opAddiu: begin
					wrReg = rt;
					res   = a + imm;
				end
				opLw: begin
					addr  = a + imm;
					wrReg = rt;
					res   = refMem[addr[7:2]];
				end
				opSw: begin
					addr = a + imm;
					refMem[addr[7:2]] = b;
					expSt.push_back('{addr: addr, data: b});
				end
				opBeq: begin
					if (a == b) begin
						nextNpc = pc + 32'd4 + (imm << 2);
					end
				end
				opJ: begin
					target  = pc + 32'd4;
					target  = {target[31:28], instr[25:0], 2'b00};
					nextNpc = target;
					// self-jump, nothing after it retires
					done    = (target == pc);
				end
				default: wrReg = 0;
			endcase
			if (wrReg != 0) begin
				regs[wrReg] = res;
				ret.group = romGroup[idx];
				ret.pc    = pc;
				ret.num   = wrReg;
				ret.data  = res;
				expRet.push_back(ret);
				groupExp[romGroup[idx]]++;
			end
			pc  = npc;
			npc = nextNpc;
			steps++;
		end
	endtask

	////////////////////////////////////////
	// checks, sampled mid-cycle
	////////////////////////////////////////

	task automatic checkRetirement();
		retire_t exp;
		int      g;
		assert (retIdx < expRet.size()) else begin
			$display("** Error at time %0t: extra retirement r%0d at pc %h",
				$time, debugWbRfWnum, debugWbPc);
			errCount++;
		end
		if (retIdx < expRet.size()) begin
			exp = expRet[retIdx];
			assert (debugWbPc == exp.pc && debugWbRfWnum == exp.num &&
				debugWbRfWdata == exp.data) else begin
				$display("** Error at time %0t: retirement %0d pc %h r%0d=%h, expected pc %h r%0d=%h",
					$time, retIdx, debugWbPc, debugWbRfWnum, debugWbRfWdata,
					exp.pc, exp.num, exp.data);
				errCount++;
			end
			g = exp.group;
			retIdx++;
			groupSeen[g]++;
			if (groupSeen[g] == groupExp[g]) begin
				$display("group %0d (%s) finished: %0d retirements, %0d errors so far",
					g, patternName[g % 5], groupSeen[g], errCount);
			end
		end
	endtask

	task automatic checkStore();
		assert (stIdx < expSt.size()) else begin
			$display("** Error at time %0t: unexpected store of %h to %h",
				$time, writeDataM, aluOutM);
			errCount++;
		end
		if (stIdx < expSt.size()) begin
			assert (aluOutM == expSt[stIdx].addr && writeDataM == expSt[stIdx].data) else begin
				$display("** Error at time %0t: store %0d wrote %h to %h, expected %h to %h",
					$time, stIdx, writeDataM, aluOutM, expSt[stIdx].data, expSt[stIdx].addr);
				errCount++;
			end
			stIdx++;
		end
	endtask

	// store lands here too, word access only
	always @(negedge clk) begin
		if (rstN && debugWbRfWen) begin
			checkRetirement();
		end
		if (rstN && memWriteM) begin
			checkStore();
			dataMem[aluOutM[7:2]] = writeDataM;
		end
	end

	initial begin
		rstN     = 1'b1;
		seed     = 56440;
		retIdx   = 0;
		stIdx    = 0;
		errCount = 0;
		for (int g = 0; g < nGroups; g++) begin
			groupExp[g]  = 0;
			groupSeen[g] = 0;
		end
		for (int i = 0; i < memWords; i++) begin
			dataMem[i] = fillWord(4 * i);
		end
		buildProgram();
		runReference();
		progReady = 1'b1;
		// reset edge well before the first clock
		#1;
		rstN = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		wait (retIdx == expRet.size() && stIdx == expSt.size());
		// drain, catches stray retirements
		repeat (10) @(posedge clk);
		$display("%0d of %0d retirements, %0d of %0d stores, %0d errors, %0d assertion failures",
			retIdx, expRet.size(), stIdx, expSt.size(), errCount, u_dut.u_chk.failCount);
		if (errCount == 0 && u_dut.u_chk.failCount == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	// watchdog, 10 cycles per instruction plus margin
	initial begin
		wait (progReady);
		#(clkPeriod * (10 * progLen + 50));
		$display("timeout: the pipeline stopped retiring after %0d of %0d retirements",
			retIdx, expRet.size());
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hdl/mipsPkg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/memWbStage.sv
hdl/mipsCore.sv
testbench/mipsCore_chk.sv
testbench/tb_mipsCore.sv
